/* common/fc_map_pkg.sv */
package fc_map_pkg;

   // byte addressed, one coefficient per address
   localparam int wb_adr_w = 9;

   // weights are class major, 48 per class
   // weight of class c, feature f at weight_base + c*48 + f
   localparam int weight_base = 0;

   // one bias per class right after the last weight
   // bias of class c at bias_base + c
   localparam int bias_base = 480;

   // first unmapped address
   // reads from here on give zero and writes are dropped
   localparam int map_end = 490;

endpackage

/* common/fc_types_pkg.sv */
package fc_types_pkg;
   import fc_map_pkg::*;

   // input stream shape
   localparam int in_lanes   = 3;
   localparam int fill_beats = 16;
   localparam int in_num     = in_lanes * fill_beats;

   // classes and the staged dot product
   localparam int out_num  = 10;
   localparam int step_num = 4;
   localparam int step_len = in_num / step_num;

   // datapath widths
   localparam int feat_w    = 12;
   localparam int ext_w     = 14;
   localparam int coef_w    = 8;
   localparam int sum_w     = 20;
   // score is sum bits 18 down to 7
   localparam int score_lsb = 7;

   typedef logic signed [feat_w-1:0] feature_t;
   typedef logic signed [coef_w-1:0] coef_t;
   typedef logic signed [11:0]       score_t;
   typedef logic [3:0]               class_idx_t;
   typedef logic [1:0]               step_idx_t;

   // one beat of the three feature lanes
   typedef struct packed {
      logic                    valid;
      feature_t [in_lanes-1:0] lane;
   } feat_beat_t;

   typedef struct packed {
      logic       valid;
      class_idx_t index;
      score_t     value;
   } fc_result_t;

   // wishbone classic, master to slave
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [wb_adr_w-1:0] adr;
      logic [7:0]          dat;
   } wb_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wb_rsp_t;

endpackage

/* source/fc_param_store.sv */
`timescale 1ns/1ps

module fc_param_store
   import fc_types_pkg::*;
   import fc_map_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  wb_req_t    wb_req,
   output wb_rsp_t    wb_rsp,
   input  class_idx_t class_idx,
   input  step_idx_t  step_idx,
   output coef_t      step_weights [step_len],
   output coef_t      class_bias
);

   // one row per class and step, twelve weights each
   coef_t weight_mem [out_num * step_num][step_len];
   coef_t bias_mem   [out_num];

   logic       bus_req;
   logic       in_weights;
   logic       in_biases;
   int         w_off;
   int         b_off;
   logic [7:0] rd_dat;
   logic       ack_q;
   logic [7:0] dat_q;

   // the ack cycle does not count as a new request
   assign bus_req = wb_req.cyc && wb_req.stb && !ack_q;

   // address decode
   assign w_off      = int'(wb_req.adr) - weight_base;
   assign b_off      = int'(wb_req.adr) - bias_base;
   assign in_weights = (w_off >= 0) && (int'(wb_req.adr) < bias_base);
   assign in_biases  = (b_off >= 0) && (int'(wb_req.adr) < map_end);

   // row is offset / 12 since a class spans exactly four rows
   always_comb begin
      rd_dat = '0;
      if (in_weights) begin
         rd_dat = weight_mem[w_off / step_len][w_off % step_len];
      end else if (in_biases) begin
         rd_dat = bias_mem[b_off];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus_req;
      end
   end

   always_ff @(posedge clk) begin
      if (bus_req && !wb_req.we) begin
         dat_q <= rd_dat;
      end
   end

   // unmapped writes fall through both branches
   always_ff @(posedge clk) begin
      if (bus_req && wb_req.we) begin
         if (in_weights) begin
            weight_mem[w_off / step_len][w_off % step_len] <= wb_req.dat;
         end else if (in_biases) begin
            bias_mem[b_off] <= wb_req.dat;
         end
      end
   end

   assign wb_rsp = '{ack: ack_q, dat: dat_q};

   // engine side, row picked by class and step
   always_comb begin
      for (int i = 0; i < step_len; i++) begin
         step_weights[i] = weight_mem[int'(class_idx) * step_num + int'(step_idx)][i];
      end
   end

   assign class_bias = bias_mem[class_idx];

endmodule

/* source/fc_input_buffer.sv */
`timescale 1ns/1ps

module fc_input_buffer
   import fc_types_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  feat_beat_t              beat,
   output logic                    in_ready,
   output logic                    frame_full,
   input  logic                    frame_done,
   input  step_idx_t               step_idx,
   output logic signed [ext_w-1:0] step_feats [step_len]
);

   logic                          full_q;
   logic [$clog2(fill_beats)-1:0] beat_cnt;
   logic                          accept;
   logic signed [ext_w-1:0]       feat_buf [in_num];

   // not ready for the whole time the engine works on the frame
   assign in_ready   = !full_q;
   assign frame_full = full_q;
   assign accept     = beat.valid && !full_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full_q   <= 1'b0;
         beat_cnt <= '0;
      end else if (frame_done) begin
         full_q <= 1'b0;
      end else if (accept) begin
         // counter wraps to zero on the sixteenth beat
         beat_cnt <= beat_cnt + 1'b1;
         if (beat_cnt == ($clog2(fill_beats))'(fill_beats - 1)) begin
            full_q <= 1'b1;
         end
      end
   end

   // lane l lands in region l*16, at the beat number
   always_ff @(posedge clk) begin
      if (accept) begin
         for (int l = 0; l < in_lanes; l++) begin
            feat_buf[l * fill_beats + int'(beat_cnt)] <=
               {{(ext_w - feat_w){beat.lane[l][feat_w-1]}}, beat.lane[l]};
         end
      end
   end

   // twelve consecutive features per step
   always_comb begin
      for (int i = 0; i < step_len; i++) begin
         step_feats[i] = feat_buf[int'(step_idx) * step_len + i];
      end
   end

endmodule

/* mac/fc_mac_engine.sv */
`timescale 1ns/1ps

module fc_mac_engine
   import fc_types_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    frame_full,
   input  logic signed [ext_w-1:0] step_feats [step_len],
   input  coef_t                   step_weights [step_len],
   input  coef_t                   class_bias,
   output step_idx_t               step_idx,
   output class_idx_t              class_idx,
   output logic                    frame_done,
   output fc_result_t              result
);

   logic                    busy;
   logic                    start;
   logic                    last_step;
   logic                    last_class;
   logic signed [sum_w-1:0] prod [step_len];
   logic signed [sum_w-1:0] step_sum;
   logic signed [sum_w-1:0] acc;
   logic signed [sum_w-1:0] acc_next;
   logic signed [sum_w-1:0] bias_ext;
   logic signed [sum_w-1:0] total;
   logic                    res_valid;
   class_idx_t              res_index;
   score_t                  res_value;

   // buffer still reports full during the frame_done cycle
   assign start      = frame_full && !busy && !frame_done;
   assign last_step  = step_idx == step_idx_t'(step_num - 1);
   assign last_class = class_idx == class_idx_t'(out_num - 1);

   // twelve multipliers, products kept modulo 2^20
   always_comb begin
      for (int i = 0; i < step_len; i++) begin
         prod[i] = step_feats[i] * step_weights[i];
      end
   end

   always_comb begin
      step_sum = '0;
      for (int i = 0; i < step_len; i++) begin
         step_sum = step_sum + prod[i];
      end
   end

   // step 0 starts a fresh sum, so the next class needs no clear cycle
   always_comb begin
      if (step_idx == '0) begin
         acc_next = step_sum;
      end else begin
         acc_next = acc + step_sum;
      end
      bias_ext = class_bias;
      total    = acc_next + bias_ext;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         step_idx   <= '0;
         class_idx  <= '0;
         frame_done <= 1'b0;
         res_valid  <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         res_valid  <= 1'b0;
         if (start) begin
            busy      <= 1'b1;
            step_idx  <= '0;
            class_idx <= '0;
         end else if (busy) begin
            step_idx <= step_idx + 1'b1;
            if (last_step) begin
               res_valid <= 1'b1;
               if (last_class) begin
                  busy       <= 1'b0;
                  frame_done <= 1'b1;
                  class_idx  <= '0;
               end else begin
                  class_idx <= class_idx + 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (busy) begin
         acc <= acc_next;
         if (last_step) begin
            res_index <= class_idx;
            res_value <= total[score_lsb +: $bits(score_t)];
         end
      end
   end

   assign result = '{valid: res_valid, index: res_index, value: res_value};

endmodule

/* source/fc_top.sv */
`timescale 1ns/1ps

module fc_top
   import fc_types_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  feat_beat_t beat,
   output logic       in_ready,
   input  wb_req_t    wb_req,
   output wb_rsp_t    wb_rsp,
   output fc_result_t result
);

   logic                    frame_full;
   logic                    frame_done;
   step_idx_t               step_idx;
   class_idx_t              class_idx;
   logic signed [ext_w-1:0] step_feats [step_len];
   coef_t                   step_weights [step_len];
   coef_t                   class_bias;

   // weights and biases, loaded over the bus
   fc_param_store u_param_store (
      .clk          (clk),
      .rst_n        (rst_n),
      .wb_req       (wb_req),
      .wb_rsp       (wb_rsp),
      .class_idx    (class_idx),
      .step_idx     (step_idx),
      .step_weights (step_weights),
      .class_bias   (class_bias)
   );

   fc_input_buffer u_input_buffer (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .in_ready   (in_ready),
      .frame_full (frame_full),
      .frame_done (frame_done),
      .step_idx   (step_idx),
      .step_feats (step_feats)
   );

   // four steps per class, ten classes per frame
   fc_mac_engine u_mac_engine (
      .clk          (clk),
      .rst_n        (rst_n),
      .frame_full   (frame_full),
      .step_feats   (step_feats),
      .step_weights (step_weights),
      .class_bias   (class_bias),
      .step_idx     (step_idx),
      .class_idx    (class_idx),
      .frame_done   (frame_done),
      .result       (result)
   );

endmodule

/* bench/fc_clk_gen.sv */
`timescale 1ns/1ps

module fc_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // four cycles of reset
   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* bench/fc_tb_model.svh */
`ifndef FC_TB_MODEL_SVH
`define FC_TB_MODEL_SVH

// shadow of every mapped byte, written alongside the bus writes
logic [7:0] shadow_mem [map_end];
// features of the frame in flight, by buffer slot
feature_t   frame_feat [in_num];

function automatic int weight_addr(input int c, input int f);
   return weight_base + c * in_num + f;
endfunction

function automatic int bias_addr(input int c);
   return bias_base + c;
endfunction

// lane l fills its own block of sixteen
function automatic int feat_slot(input int l, input int b);
   return l * fill_beats + b;
endfunction

// bias plus 48 products, wrapped to 20 bits, bits 18..7 kept
function automatic score_t expected_score(input int c);
   int          sum;
   logic [31:0] bits;
   coef_t       w;
   coef_t       bias;
   bias = shadow_mem[bias_addr(c)];
   sum  = int'(bias);
   for (int f = 0; f < in_num; f++) begin
      w   = shadow_mem[weight_addr(c, f)];
      sum = sum + int'(w) * int'(frame_feat[f]);
   end
   bits = sum;
   return score_t'(bits[18:7]);
endfunction

`endif

/* bench/fc_tb.sv */
`timescale 1ns/1ps

module fc_tb
   import fc_types_pkg::*;
   import fc_map_pkg::*;
();

   localparam int wait_limit = 200;

   logic       clk;
   logic       rst_n;
   feat_beat_t beat;
   logic       in_ready;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   fc_result_t result;
   integer     seed;
   int         check_cnt;
   int         err_cnt;
   int         timeout_cnt;
   logic       collect_done;

   `include "fc_tb_model.svh"

   fc_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   fc_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .beat     (beat),
      .in_ready (in_ready),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .result   (result)
   );

   task automatic check_score(input string name, input score_t got, input score_t exp);
      check_cnt++;
      if (got !== exp) begin
         $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_index(input string name, input class_idx_t got, input class_idx_t exp);
      check_cnt++;
      if (got !== exp) begin
         $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bus(input string name, input logic [7:0] got, input logic [7:0] exp);
      check_cnt++;
      if (got !== exp) begin
         $display("FAILED %0t %s got %02h expected %02h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp) begin
         $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      check_cnt++;
      if (got != exp) begin
         $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // one classic cycle held until ack or the limit
   task automatic wb_access(input logic we, input int adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
      int t;
      @(posedge clk);
      wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: wb_adr_w'(adr), dat: wdat};
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!wb_rsp.ack && t < wait_limit);
      if (!wb_rsp.ack) begin
         $display("timeout: no Wishbone ack for address %0d", adr);
         timeout_cnt++;
      end
      rdat = wb_rsp.dat;
      @(posedge clk);
      wb_req <= '0;
   endtask

   // write every address including the unmapped ones and read all back
   task automatic load_and_readback();
      logic [7:0] d;
      logic [7:0] rd;
      for (int a = 0; a < 2 ** wb_adr_w; a++) begin
         d = 8'($random(seed));
         wb_access(1'b1, a, d, rd);
         if (a < map_end) begin
            shadow_mem[a] = d;
         end
      end
      for (int a = 0; a < 2 ** wb_adr_w; a++) begin
         wb_access(1'b0, a, 8'h00, rd);
         check_bus($sformatf("wb_rsp.dat @%0d", a), rd, (a < map_end) ? shadow_mem[a] : 8'h00);
      end
   endtask

   task automatic rewrite_params(input int n);
      int         a;
      logic [7:0] d;
      logic [7:0] rd;
      for (int i = 0; i < n; i++) begin
         a = int'($unsigned($random(seed)) % map_end);
         d = 8'($random(seed));
         wb_access(1'b1, a, d, rd);
         shadow_mem[a] = d;
      end
   endtask

   function automatic feat_beat_t random_beat(input logic valid);
      feat_beat_t b;
      b.valid = valid;
      for (int l = 0; l < in_lanes; l++) begin
         b.lane[l] = feature_t'($random(seed));
      end
      return b;
   endfunction

   task automatic send_frame();
      feat_beat_t b;
      int         gap;
      for (int n = 0; n < fill_beats; n++) begin
         gap = $random(seed) & 3;
         repeat (gap) begin
            @(posedge clk);
            beat <= random_beat(1'b0);
         end
         b = random_beat(1'b1);
         for (int l = 0; l < in_lanes; l++) begin
            frame_feat[feat_slot(l, n)] = b.lane[l];
         end
         @(posedge clk);
         beat <= b;
      end
      // sixteenth beat is taken at this edge
      @(posedge clk);
      beat <= '0;
   endtask

   // beats offered while the frame is computed
   task automatic drive_noise();
      int t;
      t = 0;
      while (!collect_done && t < wait_limit) begin
         @(posedge clk);
         beat <= collect_done ? feat_beat_t'('0) : random_beat(1'b1);
         t++;
      end
      if (!collect_done) begin
         $display("timeout: noise driver never saw the end of the frame");
         timeout_cnt++;
      end
      beat <= '0;
   endtask

   // cycle 0 is the one right after the sixteenth beat
   task automatic collect_frame();
      int cyc;
      int got;
      int t;
      int res_cyc [out_num];
      cyc = 0;
      got = 0;
      while (got < out_num && cyc < wait_limit) begin
         @(negedge clk);
         if (result.valid) begin
            check_index("result.index", result.index, class_idx_t'(got));
            check_score($sformatf("result.value class %0d", got), result.value,
                        expected_score(got));
            res_cyc[got] = cyc;
            got++;
         end
         cyc++;
      end
      collect_done = 1'b1;
      if (got < out_num) begin
         $display("timeout: only %0d of %0d results arrived", got, out_num);
         timeout_cnt++;
      end else begin
         check_cycles("first result latency", res_cyc[0], 5);
         for (int k = 1; k < out_num; k++) begin
            check_cycles("result spacing", res_cyc[k] - res_cyc[k-1], step_num);
         end
         t = 0;
         while (!in_ready && t < wait_limit) begin
            @(negedge clk);
            check_flag("result.valid", result.valid, 1'b0);
            t++;
         end
         if (!in_ready) begin
            $display("timeout: in_ready stayed low after the last result");
            timeout_cnt++;
         end else begin
            check_cycles("in_ready rise delay", t, 1);
            // an eleventh class would show up one step later
            repeat (step_num) begin
               @(negedge clk);
               check_flag("result.valid", result.valid, 1'b0);
            end
         end
      end
   endtask

   task automatic run_frame(input logic noisy);
      send_frame();
      collect_done = 1'b0;
      fork
         collect_frame();
         begin
            if (noisy) begin
               drive_noise();
            end
         end
      join
   endtask

   initial begin
      logic [7:0] rd;
      int         t;
      seed         = 32'h8a19_8973;
      beat         = '0;
      wb_req       = '0;
      check_cnt    = 0;
      err_cnt      = 0;
      timeout_cnt  = 0;
      collect_done = 1'b0;

      t = 0;
      while (rst_n !== 1'b1 && t < wait_limit) begin
         @(negedge clk);
         t++;
      end
      if (rst_n !== 1'b1) begin
         $display("timeout: reset never released");
         timeout_cnt++;
      end

      @(negedge clk);
      check_flag("in_ready", in_ready, 1'b1);
      repeat (10) begin
         @(negedge clk);
         check_flag("result.valid", result.valid, 1'b0);
         check_flag("wb_rsp.ack", wb_rsp.ack, 1'b0);
      end
      wb_access(1'b0, bias_addr(3), 8'h00, rd);

      load_and_readback();

      // clean frame then one with dropped beats then a clean one again
      run_frame(1'b0);
      run_frame(1'b1);
      run_frame(1'b0);

      for (int n = 0; n < 4; n++) begin
         if (n % 2 == 0) begin
            rewrite_params(60);
         end
         run_frame(n == 3);
      end

      $display("checks %0d, mismatches %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+bench
common/fc_map_pkg.sv
common/fc_types_pkg.sv
source/fc_param_store.sv
source/fc_input_buffer.sv
mac/fc_mac_engine.sv
source/fc_top.sv
bench/fc_clk_gen.sv
bench/fc_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal --top-module fc_tb \
   -f all.f --Mdir obj_dir -o fc_sim

./obj_dir/fc_sim | tee sim.log

if grep -q "^Verification passed$" sim.log; then
   echo "simulation PASS"
   exit 0
else
   echo "simulation FAIL"
   exit 1
fi
